//--- hdl/parserPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parser definitions
// Opcodes, decoder states, job kinds and
// the layout of a 32-bit command word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package parserPkg;

    // Command word layout: opcode on top, byte count below
    localparam int OpPos = 28;
    localparam int OpSize = 4;
    localparam int ImmSize = 28;

    typedef enum logic [3:0] {
        Nop    = 4'd0,
        Store  = 4'd5,
        Memset = 4'd7,
        Stream = 4'd8
    } opcodeT;

    typedef enum logic [2:0] {
        Idle,
        Command,
        StoreAddr,
        MemsetAddr,
        MemsetVal,
        Run,
        WaitDone
    } parserStateT;

    // Where the streamer takes its beats from and where they go
    typedef enum logic [1:0] {
        StreamJob,
        StoreJob,
        MemsetJob
    } jobKindT;

endpackage

`default_nettype wire

//--- hdl/memBusPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bus definitions
// Burst geometry and beat size helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package memBusPkg;

    // Every memory transfer is one fixed incrementing burst of this size
    localparam int BurstBytes = 128;
    localparam logic [1:0] BurstIncr = 2'd1;

    function automatic int bytesPerBeat(input int width);
        return width / 8;
    endfunction

    // Shift that turns a byte count into a beat count
    function automatic int beatShift(input int width);
        return $clog2(width / 8);
    endfunction

    // Size code of the address channel, log2 of bytes per beat
    function automatic logic [2:0] burstSize(input int width);
        return 3'(beatShift(width));
    endfunction

endpackage

`default_nettype wire

//--- hdl/streamCtrlIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream job interface
// Hands a beat job from the decoder to
// the beat streamer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface streamCtrlIf #(
    parameter int StreamWidth = 32
);
    logic                          start;
    parserPkg::jobKindT            kind;
    logic [parserPkg::ImmSize-1:0] beatCount;
    logic [StreamWidth-1:0]        fillValue;
    logic                          busy;
    logic                          srcReady;

    modport decoder (
        output start,
        output kind,
        output beatCount,
        output fillValue,
        input  busy
    );

    modport streamer (
        input  start,
        input  beatCount,
        output busy,
        output srcReady
    );
endinterface

`default_nettype wire

//--- hdl/addrCtrlIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst address job interface
// Hands base address and length from the
// decoder to the address generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface addrCtrlIf #(
    parameter int AddrWidth = 16
);
    logic                          start;
    logic [AddrWidth-1:0]          baseAddr;
    logic [parserPkg::ImmSize-1:0] beatCount;
    logic                          busy;

    modport decoder (
        output start,
        output baseAddr,
        output beatCount,
        input  busy
    );

    modport generator (
        input  start,
        input  baseAddr,
        input  beatCount,
        output busy
    );
endinterface

`default_nettype wire

//--- hdl/commandDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command decoder
// Reads command, address and value words
// and launches streamer and address jobs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module commandDecoder #(
    parameter int StreamWidth = 32,
    parameter int AddrWidth = 16
) (
    input  logic                   aclk,
    input  logic                   resetn,
    input  logic                   cmdValid,
    output logic                   cmdReady,
    input  logic [StreamWidth-1:0] cmdData,
    streamCtrlIf.decoder           stream,
    addrCtrlIf.decoder             addr,
    output parserPkg::jobKindT     runKind,
    output logic                   running
);
    localparam int BeatShift = memBusPkg::beatShift(StreamWidth);

    parserPkg::parserStateT        state;
    parserPkg::jobKindT            kind;
    parserPkg::opcodeT             opcode;
    logic [parserPkg::ImmSize-1:0] cmdBeats;
    logic [parserPkg::ImmSize-1:0] beats;
    logic [AddrWidth-1:0]          baseAddr;
    logic [StreamWidth-1:0]        fillValue;
    logic                          take;

    assign opcode = parserPkg::opcodeT'(cmdData[parserPkg::OpPos +: parserPkg::OpSize]);
    assign cmdBeats = cmdData[parserPkg::ImmSize-1:0] >> BeatShift;

    // Words are accepted while a command or one of its parameters is expected
    assign cmdReady = (state == parserPkg::Command) || (state == parserPkg::StoreAddr)
                   || (state == parserPkg::MemsetAddr) || (state == parserPkg::MemsetVal);
    assign take = cmdValid && cmdReady;

    assign running = (state == parserPkg::Run) || (state == parserPkg::WaitDone);
    assign runKind = kind;

    // Memory jobs also need the address channel
    assign stream.start = (state == parserPkg::Run);
    assign addr.start = (state == parserPkg::Run) && (kind != parserPkg::StreamJob);

    assign stream.kind = kind;
    assign stream.beatCount = beats;
    assign stream.fillValue = fillValue;
    assign addr.beatCount = beats;
    assign addr.baseAddr = baseAddr;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= parserPkg::Idle;
            kind <= parserPkg::StreamJob;
        end
        else
        begin
            case (state)
                parserPkg::Idle:
                begin
                    state <= parserPkg::Command;
                end
                parserPkg::Command:
                begin
                    // A zero count leaves the decoder waiting for the next command
                    if (take && (cmdBeats != '0))
                    begin
                        case (opcode)
                            parserPkg::Stream:
                            begin
                                kind <= parserPkg::StreamJob;
                                state <= parserPkg::Run;
                            end
                            parserPkg::Store:
                            begin
                                kind <= parserPkg::StoreJob;
                                state <= parserPkg::StoreAddr;
                            end
                            parserPkg::Memset:
                            begin
                                kind <= parserPkg::MemsetJob;
                                state <= parserPkg::MemsetAddr;
                            end
                            default:
                            begin
                                state <= parserPkg::Command;
                            end
                        endcase
                    end
                end
                parserPkg::StoreAddr:
                begin
                    if (take)
                    begin
                        state <= parserPkg::Run;
                    end
                end
                parserPkg::MemsetAddr:
                begin
                    if (take)
                    begin
                        state <= parserPkg::MemsetVal;
                    end
                end
                parserPkg::MemsetVal:
                begin
                    if (take)
                    begin
                        state <= parserPkg::Run;
                    end
                end
                parserPkg::Run:
                begin
                    state <= parserPkg::WaitDone;
                end
                parserPkg::WaitDone:
                begin
                    if (!stream.busy && !addr.busy)
                    begin
                        state <= parserPkg::Command;
                    end
                end
                default:
                begin
                    state <= parserPkg::Idle;
                end
            endcase
        end
    end

    // Job parameters, captured on their word handshakes
    always_ff @(posedge aclk)
    begin
        if (take && (state == parserPkg::Command))
        begin
            beats <= cmdBeats;
        end
        if (take && ((state == parserPkg::StoreAddr) || (state == parserPkg::MemsetAddr)))
        begin
            baseAddr <= cmdData[AddrWidth-1:0];
        end
        if (take && (state == parserPkg::MemsetVal))
        begin
            fillValue <= cmdData;
        end
    end
endmodule

`default_nettype wire

//--- hdl/beatStreamer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat streamer
// Copies a counted number of beats to a
// registered output with a skid buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module beatStreamer #(
    parameter int StreamWidth = 32
) (
    input  logic                   aclk,
    input  logic                   resetn,
    streamCtrlIf.streamer          ctrl,
    input  logic                   srcValid,
    input  logic [StreamWidth-1:0] srcData,
    output logic                   dstValid,
    input  logic                   dstReady,
    output logic [StreamWidth-1:0] dstData,
    output logic                   streamLast,
    output logic                   burstLast
);
    localparam int BeatsPerBurst = memBusPkg::BurstBytes
                                 / memBusPkg::bytesPerBeat(StreamWidth);
    localparam int BurstBits = $clog2(BeatsPerBurst);

    logic [parserPkg::ImmSize-1:0] remaining;
    logic                          accept;
    logic                          outFree;
    logic                          inStreamLast;
    logic                          inBurstLast;
    logic                          skidValid;
    logic [StreamWidth-1:0]        skidData;
    logic                          skidStreamLast;
    logic                          skidBurstLast;

    // Source is held off while beats are pending in the skid entry
    assign ctrl.srcReady = (remaining != '0) && !skidValid;
    assign ctrl.busy = (remaining != '0) || skidValid || dstValid;

    assign accept = srcValid && ctrl.srcReady;
    assign outFree = !dstValid || dstReady;

    // Flags of the beat being accepted, from the count still to come
    assign inStreamLast = (remaining == 1);
    assign inBurstLast = (remaining[BurstBits-1:0] == BurstBits'(1));

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            remaining <= '0;
            dstValid <= 1'b0;
            skidValid <= 1'b0;
        end
        else
        begin
            if (ctrl.start)
            begin
                remaining <= ctrl.beatCount;
            end
            else if (accept)
            begin
                remaining <= remaining - 1'b1;
            end

            if (outFree)
            begin
                dstValid <= skidValid || accept;
                skidValid <= 1'b0;
            end
            else if (accept)
            begin
                // Output stalled, park this beat
                skidValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (outFree)
        begin
            if (skidValid)
            begin
                dstData <= skidData;
                streamLast <= skidStreamLast;
                burstLast <= skidBurstLast;
            end
            else if (accept)
            begin
                dstData <= srcData;
                streamLast <= inStreamLast;
                burstLast <= inBurstLast;
            end
        end
        else if (accept)
        begin
            skidData <= srcData;
            skidStreamLast <= inStreamLast;
            skidBurstLast <= inBurstLast;
        end
    end
endmodule

`default_nettype wire

//--- hdl/burstAddressGen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst address generator
// Issues one write address per burst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module burstAddressGen #(
    parameter int StreamWidth = 32,
    parameter int AddrWidth = 16
) (
    input  logic                 aclk,
    input  logic                 resetn,
    addrCtrlIf.generator         ctrl,
    output logic [AddrWidth-1:0] awAddr,
    output logic                 awValid,
    input  logic                 awReady
);
    localparam int BeatShift = memBusPkg::beatShift(StreamWidth);
    localparam logic [AddrWidth-1:0] BurstStep = AddrWidth'(memBusPkg::BurstBytes);

    logic [AddrWidth-1:0] curAddr;
    logic [AddrWidth-1:0] lastAddr;
    logic [AddrWidth-1:0] spanBytes;
    logic                 addrTaken;

    // Byte length of the whole job
    assign spanBytes = AddrWidth'(ctrl.beatCount << BeatShift);
    assign addrTaken = awValid && awReady;

    assign awAddr = curAddr;
    assign ctrl.busy = awValid;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            awValid <= 1'b0;
        end
        else if (ctrl.start)
        begin
            awValid <= 1'b1;
        end
        else if (addrTaken && (curAddr == lastAddr))
        begin
            awValid <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (ctrl.start)
        begin
            curAddr <= ctrl.baseAddr;
            lastAddr <= ctrl.baseAddr + spanBytes - BurstStep;
        end
        else if (addrTaken)
        begin
            curAddr <= curAddr + BurstStep;
        end
    end
endmodule

`default_nettype wire

//--- hdl/cmdParser.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command stream parser
// Splits a command stream into pass
// through streams and memory bursts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module cmdParser #(
    parameter int StreamWidth = 32,
    parameter int AddrWidth = 16
) (
    input  logic                       aclk,
    input  logic                       resetn,

    // Command input, frames are counted from the command word
    input  logic                       sCmdValid,
    output logic                       sCmdReady,
    input  logic                       sCmdLast,
    input  logic [StreamWidth-1:0]     sCmdData,

    output logic                       mCmdValid,
    input  logic                       mCmdReady,
    output logic                       mCmdLast,
    output logic [StreamWidth-1:0]     mCmdData,

    output logic [AddrWidth-1:0]       memAwAddr,
    output logic [7:0]                 memAwLen,
    output logic [2:0]                 memAwSize,
    output logic [1:0]                 memAwBurst,
    output logic                       memAwValid,
    input  logic                       memAwReady,

    output logic [StreamWidth-1:0]     memWData,
    output logic [StreamWidth/8-1:0]   memWStrb,
    output logic                       memWLast,
    output logic                       memWValid,
    input  logic                       memWReady,

    output logic                       memBReady
);
    localparam int BeatsPerBurst = memBusPkg::BurstBytes
                                 / memBusPkg::bytesPerBeat(StreamWidth);

    parserPkg::jobKindT     runKind;
    logic                   running;
    logic                   decCmdValid;
    logic                   decCmdReady;
    logic                   fromCmdIn;
    logic                   fromFill;
    logic                   toCmdOut;
    logic                   srcValid;
    logic [StreamWidth-1:0] srcData;
    logic                   dstValid;
    logic                   dstReady;
    logic [StreamWidth-1:0] dstData;
    logic                   streamLast;
    logic                   burstLast;

    streamCtrlIf #(.StreamWidth(StreamWidth)) streamBus ();
    addrCtrlIf #(.AddrWidth(AddrWidth)) addrBus ();

    // Source side: command words to the decoder, job beats to the streamer
    assign fromCmdIn = running && ((runKind == parserPkg::StreamJob)
                                || (runKind == parserPkg::StoreJob));
    assign fromFill = running && (runKind == parserPkg::MemsetJob);

    assign decCmdValid = sCmdValid && !running;
    assign sCmdReady = fromCmdIn ? streamBus.srcReady : decCmdReady;

    // Memset value acts as a source that never runs dry
    assign srcValid = fromFill || (fromCmdIn && sCmdValid);
    assign srcData = fromFill ? streamBus.fillValue : sCmdData;

    // Destination side
    assign toCmdOut = (streamBus.kind == parserPkg::StreamJob);
    assign dstReady = toCmdOut ? mCmdReady : memWReady;

    assign mCmdValid = dstValid && toCmdOut;
    assign mCmdLast = streamLast && toCmdOut;
    assign mCmdData = dstData;

    assign memWValid = dstValid && !toCmdOut;
    assign memWLast = burstLast && !toCmdOut;
    assign memWData = dstData;

    // Fixed burst shape, full strobes, responses always taken
    assign memAwLen = 8'(BeatsPerBurst - 1);
    assign memAwSize = memBusPkg::burstSize(StreamWidth);
    assign memAwBurst = memBusPkg::BurstIncr;
    assign memWStrb = '1;
    assign memBReady = 1'b1;

    commandDecoder #(
        .StreamWidth(StreamWidth),
        .AddrWidth(AddrWidth)
    ) decoder (
        .aclk(aclk),
        .resetn(resetn),
        .cmdValid(decCmdValid),
        .cmdReady(decCmdReady),
        .cmdData(sCmdData),
        .stream(streamBus.decoder),
        .addr(addrBus.decoder),
        .runKind(runKind),
        .running(running)
    );

    beatStreamer #(
        .StreamWidth(StreamWidth)
    ) streamer (
        .aclk(aclk),
        .resetn(resetn),
        .ctrl(streamBus.streamer),
        .srcValid(srcValid),
        .srcData(srcData),
        .dstValid(dstValid),
        .dstReady(dstReady),
        .dstData(dstData),
        .streamLast(streamLast),
        .burstLast(burstLast)
    );

    burstAddressGen #(
        .StreamWidth(StreamWidth),
        .AddrWidth(AddrWidth)
    ) addrGen (
        .aclk(aclk),
        .resetn(resetn),
        .ctrl(addrBus.generator),
        .awAddr(memAwAddr),
        .awValid(memAwValid),
        .awReady(memAwReady)
    );
endmodule

`default_nettype wire

//--- testbench/cmdParserTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command parser testbench
// Runs a table of commands through the
// parser and checks every output beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module cmdParserTb;
    localparam int BytesPerBeat = 4;
    localparam int BurstBytes = 128;
    localparam int BeatsPerBurst = BurstBytes / BytesPerBeat;
    localparam int NumRows = 7;

    typedef struct packed {
        parserPkg::opcodeT op;
        logic [27:0]       bytes;
        logic [15:0]       addr;
        logic [31:0]       fill;
        logic              pressure;
    } rowT;

    // Opcode, byte count, base address, fill value, back-pressure
    localparam rowT Tests [NumRows] = '{
        '{parserPkg::Nop,    28'd0,   16'h0000, 32'h0000_0000, 1'b0},
        '{parserPkg::Stream, 28'd64,  16'h0000, 32'h0000_0000, 1'b0},
        '{parserPkg::Stream, 28'd160, 16'h0000, 32'h0000_0000, 1'b1},
        '{parserPkg::Store,  28'd256, 16'h0100, 32'h0000_0000, 1'b1},
        '{parserPkg::Memset, 28'd384, 16'h0400, 32'hA5A5_1234, 1'b1},
        '{parserPkg::Store,  28'd0,   16'h0200, 32'h0000_0000, 1'b0},
        '{parserPkg::Stream, 28'd16,  16'h0000, 32'h0000_0000, 1'b0}
    };

    logic        aclk;
    logic        resetn;
    logic        sCmdValid;
    logic        sCmdReady;
    logic        sCmdLast;
    logic [31:0] sCmdData;
    logic        mCmdValid;
    logic        mCmdReady = 1'b0;
    logic        mCmdLast;
    logic [31:0] mCmdData;
    logic [15:0] memAwAddr;
    logic [7:0]  memAwLen;
    logic [2:0]  memAwSize;
    logic [1:0]  memAwBurst;
    logic        memAwValid;
    logic        memAwReady = 1'b0;
    logic [31:0] memWData;
    logic [3:0]  memWStrb;
    logic        memWLast;
    logic        memWValid;
    logic        memWReady = 1'b0;
    logic        memBReady;

    logic        curPressure = 1'b0;
    int          cycleCount = 0;
    int          timeoutLimit = 1000000;
    string       prevName = "start";

    // Expected and observed beats, packed with their side flags
    logic [63:0] expM[$];
    logic [63:0] gotM[$];
    logic [63:0] expW[$];
    logic [63:0] gotW[$];
    logic [63:0] expAw[$];
    logic [63:0] gotAw[$];

    cmdParser #(
        .StreamWidth(32),
        .AddrWidth(16)
    ) uut (
        .aclk(aclk),
        .resetn(resetn),
        .sCmdValid(sCmdValid),
        .sCmdReady(sCmdReady),
        .sCmdLast(sCmdLast),
        .sCmdData(sCmdData),
        .mCmdValid(mCmdValid),
        .mCmdReady(mCmdReady),
        .mCmdLast(mCmdLast),
        .mCmdData(mCmdData),
        .memAwAddr(memAwAddr),
        .memAwLen(memAwLen),
        .memAwSize(memAwSize),
        .memAwBurst(memAwBurst),
        .memAwValid(memAwValid),
        .memAwReady(memAwReady),
        .memWData(memWData),
        .memWStrb(memWStrb),
        .memWLast(memWLast),
        .memWValid(memWValid),
        .memWReady(memWReady),
        .memBReady(memBReady)
    );

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Sinks drop ready at random on rows that ask for back-pressure
    always @(posedge aclk)
    begin
        #1;
        mCmdReady = curPressure ? (($urandom % 4) != 0) : 1'b1;
        memWReady = curPressure ? (($urandom % 4) != 0) : 1'b1;
        memAwReady = (($urandom % 2) != 0);
    end

    // Transfers are recorded half a cycle before the edge that takes them
    always @(negedge aclk)
    begin
        if (mCmdValid && mCmdReady)
        begin
            gotM.push_back(64'({mCmdLast, mCmdData}));
        end
        if (memWValid && memWReady)
        begin
            gotW.push_back(64'({memWStrb, memWLast, memWData}));
        end
        if (memAwValid && memAwReady)
        begin
            gotAw.push_back(64'({memAwBurst, memAwSize, memAwLen, memAwAddr}));
        end
    end

    always @(posedge aclk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit)
        begin
            $display("Timeout, the run did not finish within %0d cycles", timeoutLimit);
            $display("Test failed");
            $fatal(1, "Run stopped on timeout");
        end
    end

    task automatic checkEqual(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic logic [31:0] beatData(input int row, input int beat);
        return {8'(row), 24'(beat)};
    endfunction

    // Presents one word on sCmd and returns just after its handshake edge
    task automatic sendWord(input logic [31:0] word);
        sCmdValid = 1'b1;
        sCmdData = word;
        @(negedge aclk);
        while (!sCmdReady)
        begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        sCmdValid = 1'b0;
    endtask

    // All output of earlier rows is complete once a new command is taken
    task automatic checkOutputs(input string name);
        int idx;
        checkEqual({name, " memBReady"}, 64'd1, 64'(memBReady));
        checkEqual({name, " mCmd count"}, 64'(expM.size()), 64'(gotM.size()));
        checkEqual({name, " memW count"}, 64'(expW.size()), 64'(gotW.size()));
        checkEqual({name, " memAw count"}, 64'(expAw.size()), 64'(gotAw.size()));
        idx = 1;
        while (expM.size() > 0)
        begin
            checkEqual($sformatf("%s mCmd beat %0d", name, idx), expM.pop_front(),
                       gotM.pop_front());
            idx++;
        end
        idx = 1;
        while (expW.size() > 0)
        begin
            checkEqual($sformatf("%s memW beat %0d", name, idx), expW.pop_front(),
                       gotW.pop_front());
            idx++;
        end
        idx = 0;
        while (expAw.size() > 0)
        begin
            checkEqual($sformatf("%s memAw burst %0d", name, idx), expAw.pop_front(),
                       gotAw.pop_front());
            idx++;
        end
    endtask

    task automatic runRow(input int r);
        rowT         row;
        int          beats;
        int          bursts;
        logic [31:0] value;
        parserPkg::opcodeT op;
        row = Tests[r];
        op = row.op;
        beats = int'(row.bytes) / BytesPerBeat;
        bursts = int'(row.bytes) / BurstBytes;
        sendWord({row.op, row.bytes});
        checkOutputs(prevName);
        // Back-pressure of this row starts once the previous job has drained
        curPressure = row.pressure;
        prevName = $sformatf("row%0d %s %0d bytes", r, op.name(), row.bytes);
        if (beats == 0)
        begin
            return;
        end
        for (int i = 1; i <= beats; i++)
        begin
            value = (op == parserPkg::Memset) ? row.fill : beatData(r, i);
            if (op == parserPkg::Stream)
            begin
                expM.push_back(64'({(i == beats), value}));
            end
            else if (op != parserPkg::Nop)
            begin
                expW.push_back(64'({4'hF, ((i % BeatsPerBurst) == 0), value}));
            end
        end
        // Memory bursts: incrementing, 4-byte beats, length 31
        for (int k = 0; k < bursts && op != parserPkg::Stream && op != parserPkg::Nop; k++)
        begin
            expAw.push_back(64'({2'd1, 3'd2, 8'd31, row.addr + 16'(k * BurstBytes)}));
        end
        if (op == parserPkg::Store || op == parserPkg::Memset)
        begin
            sendWord(32'(row.addr));
        end
        if (op == parserPkg::Memset)
        begin
            sendWord(row.fill);
        end
        if (op == parserPkg::Stream || op == parserPkg::Store)
        begin
            for (int i = 1; i <= beats; i++)
            begin
                sendWord(beatData(r, i));
            end
        end
    endtask

    initial
    begin
        int totalBeats;
        void'($urandom(32'h407));
        totalBeats = 0;
        for (int r = 0; r < NumRows; r++)
        begin
            totalBeats += int'(Tests[r].bytes) / BytesPerBeat;
        end
        timeoutLimit = totalBeats * 8 + 200;
        resetn = 1'b0;
        sCmdValid = 1'b0;
        sCmdLast = 1'b0;
        sCmdData = '0;
        repeat (3) @(posedge aclk);
        #1;
        resetn = 1'b1;
        checkEqual("after reset", 64'd0,
                   64'({sCmdReady, mCmdValid, memWValid, memAwValid}));
        for (int r = 0; r < NumRows; r++)
        begin
            runRow(r);
        end
        // A closing NOP shows the last job finished and lets it be checked
        sendWord({parserPkg::Nop, 28'd0});
        checkOutputs(prevName);
        $display("Test completed successfully");
        $finish;
    end
endmodule

`default_nettype wire

//--- build.f
hdl/parserPkg.sv
hdl/memBusPkg.sv
hdl/streamCtrlIf.sv
hdl/addrCtrlIf.sv
hdl/commandDecoder.sv
hdl/beatStreamer.sv
hdl/burstAddressGen.sv
hdl/cmdParser.sv
testbench/cmdParserTb.sv

//--- Makefile
# Verilator simulation of the command stream parser

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module cmdParserTb -f build.f
	./obj_dir/VcmdParserTb | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
